/* common/fp_pkg.sv */
// Shared word, field and product types, operation codes and special constants
`default_nettype none

package fp_pkg;
    // Raw register word, used for operands and results
    typedef logic [31:0] scalar_t;

    // Biased IEEE single exponent
    typedef logic [7:0] exponent_t;

    // Significand with the hidden bit at the top
    typedef logic [23:0] significand_t;

    // Full 32x32 multiplier output
    typedef logic [63:0] product_t;

    // Hardware thread index, four threads
    typedef logic [1:0] thread_idx_t;

    typedef logic [2:0] fp_op_t;

    // Float ops
    localparam fp_op_t OP_FADD = 3'd0;
    localparam fp_op_t OP_FSUB = 3'd1;
    localparam fp_op_t OP_FMUL = 3'd2;

    // Integer multiplies on the same array
    localparam fp_op_t OP_IMUL_LO = 3'd3;
    localparam fp_op_t OP_IMULH_S = 3'd4;

    // Exponent bias and the all-ones exponent of inf/NaN
    localparam int EXP_BIAS = 127;
    localparam exponent_t EXP_MAX = 8'hff;

    // Canonical quiet NaN for every NaN result
    localparam scalar_t QNAN_VALUE = 32'h7fc00000;
endpackage

`default_nettype wire

/* fp_execute/fp_align_multiply_stage.sv */
// Second FP stage: smaller-addend alignment with guard/round/sticky and 64-bit multiply
`default_nettype none

module fp_align_multiply_stage(
    input logic                     clk,
    input logic                     reset,
    input logic                     rollback_en,
    input fp_pkg::thread_idx_t      rollback_thread,
    input logic                     dc_valid,
    input fp_pkg::fp_op_t           dc_op,
    input fp_pkg::thread_idx_t      dc_thread,
    input logic                     dc_result_inf,
    input logic                     dc_result_nan,
    input fp_pkg::significand_t     dc_significand_le,
    input fp_pkg::significand_t     dc_significand_se,
    input logic [5:0]               dc_align_shift,
    input fp_pkg::exponent_t        dc_add_exponent,
    input logic                     dc_logical_subtract,
    input logic                     dc_add_sign,
    input logic [9:0]               dc_mul_exponent,
    input logic                     dc_mul_sign,
    input fp_pkg::scalar_t          dc_multiplicand,
    input fp_pkg::scalar_t          dc_multiplier,
    output logic                    ex_valid,
    output fp_pkg::fp_op_t          ex_op,
    output fp_pkg::thread_idx_t     ex_thread,
    output logic                    ex_result_inf,
    output logic                    ex_result_nan,
    output fp_pkg::significand_t    ex_significand_le,
    output fp_pkg::significand_t    ex_significand_se,
    output logic                    ex_guard,
    output logic                    ex_round,
    output logic                    ex_sticky,
    output fp_pkg::exponent_t       ex_add_exponent,
    output logic                    ex_logical_subtract,
    output logic                    ex_add_sign,
    output fp_pkg::product_t        ex_product,
    output logic [9:0]              ex_mul_exponent,
    output logic                    ex_mul_sign);

    fp_pkg::significand_t aligned;
    logic guard;
    logic round;
    logic [24:0] sticky_bits;
    logic signed_high;
    fp_pkg::product_t multiplicand_ext;
    fp_pkg::product_t multiplier_ext;

    // Shift in a 27-bit tail so nothing shifted out is lost
    assign {aligned, guard, round, sticky_bits} = {dc_significand_se, 27'd0} >> dc_align_shift;

    // Only the signed high-word multiply sign-extends
    assign signed_high = dc_op == fp_pkg::OP_IMULH_S;
    assign multiplicand_ext = {{32{signed_high && dc_multiplicand[31]}}, dc_multiplicand};
    assign multiplier_ext = {{32{signed_high && dc_multiplier[31]}}, dc_multiplier};

    always_ff @(posedge clk)
    begin
        ex_op <= dc_op;
        ex_thread <= dc_thread;
        ex_result_inf <= dc_result_inf;
        ex_result_nan <= dc_result_nan;
        ex_significand_le <= dc_significand_le;
        ex_significand_se <= aligned;
        ex_guard <= guard;
        ex_round <= round;
        ex_sticky <= |sticky_bits;
        ex_add_exponent <= dc_add_exponent;
        ex_logical_subtract <= dc_logical_subtract;
        ex_add_sign <= dc_add_sign;
        ex_product <= multiplicand_ext * multiplier_ext;
        ex_mul_exponent <= dc_mul_exponent;
        ex_mul_sign <= dc_mul_sign;
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            ex_valid <= 1'b0;
        else
            ex_valid <= dc_valid && !(rollback_en && rollback_thread == dc_thread);
    end
endmodule

`default_nettype wire

/* fp_execute/fp_decode_stage.sv */
// First FP stage: operand unpack, addend ordering, exponent sum and special-result flags
`default_nettype none

module fp_decode_stage(
    input logic                     clk,
    input logic                     reset,
    input logic                     in_valid,
    input fp_pkg::fp_op_t           in_op,
    input fp_pkg::thread_idx_t      in_thread,
    input fp_pkg::scalar_t          in_operand_a,
    input fp_pkg::scalar_t          in_operand_b,
    input logic                     rollback_en,
    input fp_pkg::thread_idx_t      rollback_thread,
    output logic                    dc_valid,
    output fp_pkg::fp_op_t          dc_op,
    output fp_pkg::thread_idx_t     dc_thread,
    output logic                    dc_result_inf,
    output logic                    dc_result_nan,
    output fp_pkg::significand_t    dc_significand_le,
    output fp_pkg::significand_t    dc_significand_se,
    output logic [5:0]              dc_align_shift,
    output fp_pkg::exponent_t       dc_add_exponent,
    output logic                    dc_logical_subtract,
    output logic                    dc_add_sign,
    output logic [9:0]              dc_mul_exponent,
    output logic                    dc_mul_sign,
    output fp_pkg::scalar_t         dc_multiplicand,
    output fp_pkg::scalar_t         dc_multiplier);

    fp_pkg::exponent_t exp_a;
    fp_pkg::exponent_t exp_b;
    logic [22:0] frac_a;
    logic [22:0] frac_b;
    logic zero_a;
    logic zero_b;
    logic inf_a;
    logic inf_b;
    logic nan_a;
    logic nan_b;
    fp_pkg::significand_t sig_a;
    fp_pkg::significand_t sig_b;
    logic add_sign_b;
    logic a_larger;
    fp_pkg::exponent_t exp_diff;
    logic is_add;
    logic is_mul;
    logic logical_subtract;
    logic result_nan;

    // Subnormals flush to zero, so a zero exponent clears the fraction too
    assign exp_a = in_operand_a[30:23];
    assign exp_b = in_operand_b[30:23];
    assign zero_a = exp_a == '0;
    assign zero_b = exp_b == '0;
    assign frac_a = zero_a ? '0 : in_operand_a[22:0];
    assign frac_b = zero_b ? '0 : in_operand_b[22:0];
    assign inf_a = exp_a == fp_pkg::EXP_MAX && frac_a == '0;
    assign inf_b = exp_b == fp_pkg::EXP_MAX && frac_b == '0;
    assign nan_a = exp_a == fp_pkg::EXP_MAX && frac_a != '0;
    assign nan_b = exp_b == fp_pkg::EXP_MAX && frac_b != '0;
    assign sig_a = {!zero_a, frac_a};
    assign sig_b = {!zero_b, frac_b};

    assign is_add = in_op == fp_pkg::OP_FADD || in_op == fp_pkg::OP_FSUB;
    assign is_mul = in_op == fp_pkg::OP_FMUL;

    // Subtract is an add with b negated
    assign add_sign_b = in_operand_b[31] ^ (in_op == fp_pkg::OP_FSUB);
    assign logical_subtract = in_operand_a[31] ^ add_sign_b;

    // Magnitude compare on exponent and fraction together
    assign a_larger = {exp_a, frac_a} >= {exp_b, frac_b};
    assign exp_diff = a_larger ? exp_a - exp_b : exp_b - exp_a;

    assign result_nan = nan_a || nan_b
        || (is_add && inf_a && inf_b && logical_subtract)
        || (is_mul && ((inf_a && zero_b) || (zero_a && inf_b)));

    always_ff @(posedge clk)
    begin
        dc_op <= in_op;
        dc_thread <= in_thread;
        dc_result_nan <= (is_add || is_mul) && result_nan;
        dc_result_inf <= (is_add || is_mul) && !result_nan && (inf_a || inf_b);
        dc_significand_le <= a_larger ? sig_a : sig_b;
        dc_significand_se <= a_larger ? sig_b : sig_a;
        // Anything past 27 lands entirely in sticky
        dc_align_shift <= (exp_diff > 8'd27) ? 6'd27 : exp_diff[5:0];
        dc_add_exponent <= a_larger ? exp_a : exp_b;
        dc_logical_subtract <= logical_subtract;
        dc_add_sign <= a_larger ? in_operand_a[31] : add_sign_b;
        dc_mul_exponent <= {2'b00, exp_a} + {2'b00, exp_b} - 10'(fp_pkg::EXP_BIAS);
        dc_mul_sign <= in_operand_a[31] ^ in_operand_b[31];
        dc_multiplicand <= is_mul ? {8'h00, sig_a} : in_operand_a;
        dc_multiplier <= is_mul ? {8'h00, sig_b} : in_operand_b;
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            dc_valid <= 1'b0;
        else
            dc_valid <= in_valid && !(rollback_en && rollback_thread == in_thread);
    end
endmodule

`default_nettype wire

/* fp_execute/fp_result_stage.sv */
// Third FP stage: normalize, round to nearest even, pack and select the final result
`default_nettype none

module fp_result_stage(
    input logic                     clk,
    input logic                     reset,
    input logic                     ex_valid,
    input fp_pkg::fp_op_t           ex_op,
    input fp_pkg::thread_idx_t      ex_thread,
    input logic                     ex_result_inf,
    input logic                     ex_result_nan,
    input fp_pkg::significand_t     ex_significand_le,
    input fp_pkg::significand_t     ex_significand_se,
    input logic                     ex_guard,
    input logic                     ex_round,
    input logic                     ex_sticky,
    input fp_pkg::exponent_t        ex_add_exponent,
    input logic                     ex_logical_subtract,
    input logic                     ex_add_sign,
    input fp_pkg::product_t         ex_product,
    input logic [9:0]               ex_mul_exponent,
    input logic                     ex_mul_sign,
    output logic                    result_valid,
    output fp_pkg::thread_idx_t     result_thread,
    output fp_pkg::scalar_t         result_value);

    logic [27:0] add_sum;
    logic [4:0] add_lz;
    logic [26:0] add_normalized;
    logic signed [9:0] add_exponent;
    logic [47:0] mul_normalized;
    logic is_mul;
    fp_pkg::significand_t norm_significand;
    logic norm_guard;
    logic norm_round;
    logic norm_sticky;
    logic signed [9:0] norm_exponent;
    logic norm_zero;
    logic norm_sign;
    logic [24:0] rounded;
    logic signed [9:0] final_exponent;
    logic [22:0] final_fraction;
    fp_pkg::scalar_t next_value;

    function automatic logic [4:0] count_leading_zeros(input logic [26:0] value);
        logic [4:0] count;
        logic found;
        count = 5'd27;
        found = 1'b0;
        for (int i = 26; i >= 0; i--)
        begin
            if (!found && value[i])
            begin
                count = 5'(26 - i);
                found = 1'b1;
            end
        end
        return count;
    endfunction

    // Both addends widened with a carry bit on top and G/R/S below
    assign add_sum = ex_logical_subtract
        ? {1'b0, ex_significand_le, 3'b000} - {1'b0, ex_significand_se, ex_guard, ex_round, ex_sticky}
        : {1'b0, ex_significand_le, 3'b000} + {1'b0, ex_significand_se, ex_guard, ex_round, ex_sticky};
    assign add_lz = count_leading_zeros(add_sum[26:0]);

    // Carry out shifts right and keeps the lost bit in sticky, cancellation shifts left
    assign add_normalized = add_sum[27] ? {add_sum[27:2], add_sum[1] | add_sum[0]}
        : add_sum[26:0] << add_lz;
    assign add_exponent = add_sum[27]
        ? $signed({2'b00, ex_add_exponent}) + 10'sd1
        : $signed({2'b00, ex_add_exponent}) - $signed({5'd0, add_lz});

    // Hidden bit of the product sits at 47 or 46
    assign mul_normalized = ex_product[47] ? ex_product[47:0] : {ex_product[46:0], 1'b0};

    assign is_mul = ex_op == fp_pkg::OP_FMUL;

    always_comb
    begin
        if (is_mul)
        begin
            norm_significand = mul_normalized[47:24];
            norm_guard = mul_normalized[23];
            norm_round = mul_normalized[22];
            norm_sticky = |mul_normalized[21:0];
            norm_exponent = $signed(ex_mul_exponent) + (ex_product[47] ? 10'sd1 : 10'sd0);
            norm_zero = ex_product[47:46] == 2'b00;
            norm_sign = ex_mul_sign;
        end
        else
        begin
            norm_significand = add_normalized[26:3];
            norm_guard = add_normalized[2];
            norm_round = add_normalized[1];
            norm_sticky = add_normalized[0];
            norm_exponent = add_exponent;
            norm_zero = add_sum == '0;
            // Exact cancellation gives +0
            norm_sign = ex_add_sign && !(norm_zero && ex_logical_subtract);
        end
    end

    // Round to nearest, ties to even
    assign rounded = {1'b0, norm_significand}
        + 25'(norm_guard && (norm_round || norm_sticky || norm_significand[0]));
    assign final_exponent = norm_exponent + (rounded[24] ? 10'sd1 : 10'sd0);
    assign final_fraction = rounded[24] ? rounded[23:1] : rounded[22:0];

    always_comb
    begin
        if (ex_op == fp_pkg::OP_IMUL_LO)
            next_value = ex_product[31:0];
        else if (ex_op == fp_pkg::OP_IMULH_S)
            next_value = ex_product[63:32];
        else if (ex_result_nan)
            next_value = fp_pkg::QNAN_VALUE;
        else if (ex_result_inf || final_exponent >= 10'sd255)
            next_value = {is_mul ? ex_mul_sign : ex_add_sign, fp_pkg::EXP_MAX, 23'd0};
        else if (norm_zero || final_exponent <= 10'sd0)
            next_value = {norm_sign, 31'd0};
        else
            next_value = {norm_sign, final_exponent[7:0], final_fraction};
    end

    always_ff @(posedge clk)
    begin
        result_thread <= ex_thread;
        result_value <= next_value;
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            result_valid <= 1'b0;
        else
            result_valid <= ex_valid;
    end
endmodule

`default_nettype wire

/* fp_pipeline.f */
common/fp_pkg.sv
fp_execute/fp_decode_stage.sv
fp_execute/fp_align_multiply_stage.sv
fp_execute/fp_result_stage.sv
source/fp_pipeline.sv
sim/fp_pipeline_asserts.sv
sim/fp_pipeline_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the pipeline testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f fp_pipeline.f --top-module fp_pipeline_tb -o fp_pipeline_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/fp_pipeline_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^SIMULATION PASSED$" "$LOG"; then
    exit 0
fi
exit 1

/* sim/fp_pipeline_asserts.sv */
// Bound checks on result_valid around reset and its fixed latency from in_valid
`default_nettype none

module fp_pipeline_asserts(
    input logic clk,
    input logic reset,
    input logic in_valid,
    input logic result_valid);

    timeunit 1ns;
    timeprecision 1ps;

    // Cleared asynchronously while reset is high
    valid_low_in_reset: assert property (@(posedge clk) reset |-> !result_valid)
        else $error("result_valid is high while reset is asserted");

    // Pipeline still empty on the first edge after reset is released
    valid_low_after_reset: assert property (@(posedge clk) $fell(reset) |=> !result_valid)
        else $error("result_valid is high in the cycle after reset");

    valid_known: assert property (@(posedge clk) disable iff (reset)
        !$isunknown(result_valid))
        else $error("result_valid is unknown after reset");

    // Three register stages, a squash can only remove a result
    valid_has_issue: assert property (@(posedge clk) disable iff (reset)
        result_valid |-> $past(in_valid, 3))
        else $error("result_valid without in_valid three cycles earlier");
endmodule

`default_nettype wire

/* sim/fp_pipeline_tb.sv */
// Testbench for the FP execute pipeline with file stimulus, scoreboard and summary report
`default_nettype none

module fp_pipeline_tb;
    timeunit 1ns;
    timeprecision 1ps;

    // Register stages between in_valid and result_valid
    localparam int LATENCY = 3;
    localparam int DRAIN_TIMEOUT = 20;

    logic clk;
    logic reset;
    logic in_valid;
    fp_pkg::fp_op_t in_op;
    fp_pkg::thread_idx_t in_thread;
    fp_pkg::scalar_t in_operand_a;
    fp_pkg::scalar_t in_operand_b;
    logic rollback_en;
    fp_pkg::thread_idx_t rollback_thread;
    logic result_valid;
    fp_pkg::thread_idx_t result_thread;
    fp_pkg::scalar_t result_value;

    // Outstanding results, oldest first
    fp_pkg::scalar_t expected_value[$];
    fp_pkg::thread_idx_t expected_thread[$];
    int expected_cycle[$];

    int cycle = 0;
    int seed;
    int errors;
    int test_errors;
    int test_checked;
    int total_checked;
    int tests_done;

    fp_pipeline dut(.*);

    bind fp_pipeline fp_pipeline_asserts assert_checks(
        .clk(clk),
        .reset(reset),
        .in_valid(in_valid),
        .result_valid(result_valid));

    always #10 clk = !clk;

    always @(posedge clk)
        cycle <= cycle + 1;

    task automatic apply_idle();
        in_valid = 1'b0;
        rollback_en = 1'b0;
    endtask

    // Compares a presented result with the oldest expectation
    task automatic check_outputs();
        if (result_valid)
        begin
            assert (expected_value.size() != 0)
            else
            begin
                $display("Result %h from thread %0d came out with nothing outstanding",
                    result_value, result_thread);
                test_errors++;
            end
            if (expected_value.size() != 0)
            begin
                assert (result_value == expected_value[0])
                else
                begin
                    $display("FAIL result_value expected %h got %h",
                        expected_value[0], result_value);
                    test_errors++;
                end
                assert (result_thread == expected_thread[0])
                else
                begin
                    $display("FAIL result_thread expected %h got %h",
                        expected_thread[0], result_thread);
                    test_errors++;
                end
                assert (cycle == expected_cycle[0])
                else
                begin
                    $display("Result came out on cycle %0d but was due on cycle %0d",
                        cycle, expected_cycle[0]);
                    test_errors++;
                end
                void'(expected_value.pop_front());
                void'(expected_thread.pop_front());
                void'(expected_cycle.pop_front());
                test_checked++;
            end
        end
    endtask

    // Outputs are sampled on the falling edge, before new inputs go out
    task automatic step_cycle();
        @(negedge clk);
        check_outputs();
    endtask

    task automatic issue_line(input fp_pkg::fp_op_t op, input fp_pkg::thread_idx_t thread,
        input fp_pkg::scalar_t a, input fp_pkg::scalar_t b, input logic rb_en,
        input fp_pkg::thread_idx_t rb_thread, input fp_pkg::scalar_t value,
        input logic appears);
        step_cycle();
        in_valid = 1'b1;
        in_op = op;
        in_thread = thread;
        in_operand_a = a;
        in_operand_b = b;
        rollback_en = rb_en;
        rollback_thread = rb_thread;
        if (appears)
        begin
            expected_value.push_back(value);
            expected_thread.push_back(thread);
            expected_cycle.push_back(cycle + LATENCY);
        end
    endtask

    // Drains the pipeline, then reports the test
    task automatic finish_test(input int test_id);
        int waited;
        waited = 0;
        while ((expected_value.size() != 0 || waited <= LATENCY) && waited < DRAIN_TIMEOUT)
        begin
            step_cycle();
            apply_idle();
            waited++;
        end
        assert (expected_value.size() == 0)
        else
        begin
            $display("Test %0d timed out with %0d results never produced",
                test_id, expected_value.size());
            test_errors += expected_value.size();
            expected_value.delete();
            expected_thread.delete();
            expected_cycle.delete();
        end
        $display("Test %0d finished: %0d results checked, %0d errors",
            test_id, test_checked, test_errors);
        errors += test_errors;
        total_checked += test_checked;
        test_errors = 0;
        test_checked = 0;
        tests_done++;
    endtask

    initial
    begin
        int fd;
        int test_id;
        int current_test;
        int idle_cycles;
        string line;
        logic [31:0] f_op;
        logic [31:0] f_thread;
        logic [31:0] f_a;
        logic [31:0] f_b;
        logic [31:0] f_rb_en;
        logic [31:0] f_rb_thread;
        logic [31:0] f_expected;
        logic [31:0] f_appears;

        seed = 82936;
        errors = 0;
        test_errors = 0;
        test_checked = 0;
        total_checked = 0;
        tests_done = 0;
        current_test = 0;
        clk = 1'b0;
        reset = 1'b1;
        apply_idle();
        in_op = fp_pkg::OP_FADD;
        in_thread = '0;
        in_operand_a = '0;
        in_operand_b = '0;
        rollback_thread = '0;
        repeat (10) @(negedge clk);
        reset = 1'b0;

        fd = $fopen("sim/fp_stimulus.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open sim/fp_stimulus.txt for reading");
            $display("SIMULATION FAILED");
            $finish;
        end
        else
        begin
            while (!$feof(fd))
            begin
                line = "";
                void'($fgets(line, fd));
                if ($sscanf(line, "%d %h %h %h %h %h %h %h %h", test_id, f_op, f_thread,
                    f_a, f_b, f_rb_en, f_rb_thread, f_expected, f_appears) == 9)
                begin
                    if (test_id != current_test && current_test != 0)
                        finish_test(current_test);
                    current_test = test_id;
                    // A gap here would move the previous slot out of reach of a rollback
                    if (f_rb_en[0] == 1'b0)
                    begin
                        idle_cycles = $unsigned($random(seed)) % 3;
                        repeat (idle_cycles)
                        begin
                            step_cycle();
                            apply_idle();
                        end
                    end
                    issue_line(f_op[2:0], f_thread[1:0], f_a, f_b, f_rb_en[0],
                        f_rb_thread[1:0], f_expected, f_appears[0]);
                end
            end
            $fclose(fd);
            if (current_test != 0)
                finish_test(current_test);
            assert (tests_done != 0)
            else
            begin
                $display("No instruction lines were found in the stimulus file");
                errors++;
            end
            $display("Summary: %0d tests, %0d results checked, %0d errors",
                tests_done, total_checked, errors);
            if (errors == 0)
                $display("SIMULATION PASSED");
            else
                $display("SIMULATION FAILED");
            $finish;
        end
    end
endmodule

`default_nettype wire

/* sim/fp_stimulus.txt */
# test op thread operand_a operand_b rollback_en rollback_thread expected appears
# op 0 fadd, 1 fsub, 2 fmul, 3 imul low, 4 imul high signed; all but test in hex
1 0 0 3f800000 3f800000 0 0 40000000 1
1 0 1 3fc00000 3e800000 0 0 3fe00000 1
1 1 2 3f800000 3fc00000 0 0 bf000000 1
1 1 3 3f800001 3f800000 0 0 34000000 1
1 1 0 40490fdb 40490fdb 0 0 00000000 1
2 0 1 3f800000 33800000 0 0 3f800000 1
2 0 2 3f800001 33800000 0 0 3f800002 1
2 0 3 3f800000 33c00000 0 0 3f800001 1
2 0 0 3f800000 30800000 0 0 3f800000 1
2 1 1 3f800000 30800000 0 0 3f800000 1
3 2 0 3fc00000 3fc00000 0 0 40100000 1
3 2 1 c0200000 40800000 0 0 c1200000 1
3 2 2 3f800001 3f800001 0 0 3f800002 1
3 2 3 7f000000 40000000 0 0 7f800000 1
3 2 0 7f000000 c0800000 0 0 ff800000 1
3 2 1 1f800000 9f800000 0 0 80000000 1
4 0 2 7f800001 3f800000 0 0 7fc00000 1
4 1 3 7f800000 7f800000 0 0 7fc00000 1
4 2 0 00000000 ff800000 0 0 7fc00000 1
4 0 1 7f800000 40a00000 0 0 7f800000 1
4 0 2 00400000 3f800000 0 0 3f800000 1
5 3 0 fffffffe 00000003 0 0 fffffffa 1
5 4 1 fffffffe 00000003 0 0 ffffffff 1
5 4 2 ffffffff ffffffff 0 0 00000000 1
5 4 3 80000000 00000002 0 0 ffffffff 1
5 3 0 7fc00000 00000002 0 0 ff800000 1
6 0 0 3f800000 3f800000 0 0 40000000 1
6 0 1 40000000 40000000 0 0 40800000 0
6 2 2 40400000 40000000 1 1 40c00000 1
6 0 1 3f800000 40000000 1 1 40400000 0
6 3 3 00000007 00000006 0 0 0000002a 1
6 1 3 40000000 3f800000 0 0 3f800000 1
6 0 3 3f800000 40000000 0 0 40400000 0
6 2 1 40000000 40000000 1 3 40800000 1
6 0 2 3f800000 3f800000 1 2 40000000 0

/* source/fp_pipeline.sv */
// Top level of the three-stage FP execute pipeline
`default_nettype none

module fp_pipeline(
    input logic                     clk,
    input logic                     reset,
    input logic                     in_valid,
    input fp_pkg::fp_op_t           in_op,
    input fp_pkg::thread_idx_t      in_thread,
    input fp_pkg::scalar_t          in_operand_a,
    input fp_pkg::scalar_t          in_operand_b,
    input logic                     rollback_en,
    input fp_pkg::thread_idx_t      rollback_thread,
    output logic                    result_valid,
    output fp_pkg::thread_idx_t     result_thread,
    output fp_pkg::scalar_t         result_value);

    // Decode to execute
    logic dc_valid;
    fp_pkg::fp_op_t dc_op;
    fp_pkg::thread_idx_t dc_thread;
    logic dc_result_inf;
    logic dc_result_nan;
    fp_pkg::significand_t dc_significand_le;
    fp_pkg::significand_t dc_significand_se;
    logic [5:0] dc_align_shift;
    fp_pkg::exponent_t dc_add_exponent;
    logic dc_logical_subtract;
    logic dc_add_sign;
    logic [9:0] dc_mul_exponent;
    logic dc_mul_sign;
    fp_pkg::scalar_t dc_multiplicand;
    fp_pkg::scalar_t dc_multiplier;

    // Execute to result
    logic ex_valid;
    fp_pkg::fp_op_t ex_op;
    fp_pkg::thread_idx_t ex_thread;
    logic ex_result_inf;
    logic ex_result_nan;
    fp_pkg::significand_t ex_significand_le;
    fp_pkg::significand_t ex_significand_se;
    logic ex_guard;
    logic ex_round;
    logic ex_sticky;
    fp_pkg::exponent_t ex_add_exponent;
    logic ex_logical_subtract;
    logic ex_add_sign;
    fp_pkg::product_t ex_product;
    logic [9:0] ex_mul_exponent;
    logic ex_mul_sign;

    fp_decode_stage fp_decode_stage(.*);

    fp_align_multiply_stage fp_align_multiply_stage(.*);

    fp_result_stage fp_result_stage(.*);
endmodule

`default_nettype wire
